// ==== verilog/zxmem_bus_pkg.sv ====
`default_nettype none

package zxmem_bus_pkg;

   // Kind of Z80 bus cycle seen on the strobes
   typedef enum logic [2:0] {
      CYC_IDLE   = 3'd0,
      CYC_FETCH  = 3'd1,        // M1 opcode read
      CYC_MEM_RD = 3'd2,
      CYC_MEM_WR = 3'd3,
      CYC_IO_RD  = 3'd4,
      CYC_IO_WR  = 3'd5
   } cycle_kind_e;

   // DivMMC automapper entry points
   localparam logic [15:0] TRAP_RST00     = 16'h0000;
   localparam logic [15:0] TRAP_RST08     = 16'h0008;
   localparam logic [15:0] TRAP_RST38     = 16'h0038;
   localparam logic [15:0] TRAP_NMI       = 16'h0066;
   localparam logic [15:0] TRAP_TAPE_LOAD = 16'h04C6;
   localparam logic [15:0] TRAP_TAPE_SAVE = 16'h0562;
   localparam logic [7:0]  TRAP_IMM_PAGE  = 8'h3D;      // $3Dxx maps at once
   localparam logic [12:0] TRAP_EXIT_TAG  = 13'h03FF;   // $1FF8-$1FFF

   typedef struct packed {
      cycle_kind_e  kind;
      logic [15:0]  addr;
      logic [1:0]   region;          // a[15:14]
      logic         io_wr_pulse;     // First clock of an I/O write only
      logic [7:0]   wdata;
      logic         hit_7ffd;
      logic         hit_1ffd;
      logic         hit_e3;
      logic         trap_deferred;
      logic         trap_immediate;
      logic         trap_exit;
      logic         m1_end;
   } bus_cycle_t;

endpackage

`default_nettype wire

// ==== verilog/zxmem_map_pkg.sv ====
`default_nettype none

package zxmem_map_pkg;

   // Boot-time configuration registers on APB
   localparam logic [7:0] MASTERCONF_ADDR   = 8'h00;
   localparam logic [7:0] MASTERMAPPER_ADDR = 8'h01;

   // 16K RAM pages in the low 128K of SRAM
   localparam logic [2:0] PAGE_RAM0 = 3'd0;
   localparam logic [2:0] PAGE_RAM1 = 3'd1;
   localparam logic [2:0] PAGE_RAM2 = 3'd2;
   localparam logic [2:0] PAGE_RAM3 = 3'd3;
   localparam logic [2:0] PAGE_RAM4 = 3'd4;
   localparam logic [2:0] PAGE_RAM5 = 3'd5;
   localparam logic [2:0] PAGE_RAM6 = 3'd6;
   localparam logic [2:0] PAGE_RAM7 = 3'd7;

   ////////////////////////////////////////////////////////////////////////////
   // SRAM area prefixes
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [2:0] SYSROM_PREFIX      = 3'b010;     // Four 16K system ROMs
   localparam logic [5:0] DIVMMC_ROM_PREFIX  = 6'b011000;  // 8K DivMMC ROM
   localparam logic [1:0] DIVMMC_RAM_PREFIX  = 2'b10;      // 16 pages of 8K
   localparam logic [3:0] DIVMMC_MAPRAM_PAGE = 4'd3;

   typedef struct packed {
      logic         boot_mode;
      logic         divmmc_enabled;
      logic         divmmc_nmi_disabled;
      logic [4:0]   mastermapper;
      logic [7:0]   bank128;         // Port $7FFD
      logic [7:0]   bankplus3;       // Port $1FFD
      logic [7:0]   divmmc_ctrl;     // Port $E3
      logic         divmmc_paged;
   } paging_state_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_cycle_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_cycle_decode import zxmem_bus_pkg::*; (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   output bus_cycle_t  cycle
);

   cycle_kind_e kind;
   logic        io_wr;
   logic        io_wr_q;
   logic        fetch;

   always_comb begin
      if (!mreq_n && !rd_n && !m1_n)  kind = CYC_FETCH;
      else if (!mreq_n && !rd_n)      kind = CYC_MEM_RD;
      else if (!mreq_n && !wr_n)      kind = CYC_MEM_WR;
      else if (!iorq_n && !rd_n)      kind = CYC_IO_RD;
      else if (!iorq_n && !wr_n)      kind = CYC_IO_WR;
      else                            kind = CYC_IDLE;
   end

   assign io_wr = (kind == CYC_IO_WR);
   assign fetch = (kind == CYC_FETCH);

   // Strobes may be held for several clocks
   always_ff @(posedge clk) begin
      if (!mrst_n) io_wr_q <= 1'b0;
      else         io_wr_q <= io_wr;
   end

   always_comb begin
      cycle.kind        = kind;
      cycle.addr        = a;
      cycle.region      = a[15:14];
      cycle.io_wr_pulse = io_wr && !io_wr_q;
      cycle.wdata       = din;
      cycle.hit_7ffd    = a[0] && !a[1] && a[14] && !a[15];
      cycle.hit_1ffd    = a[0] && !a[1] && a[12] && (a[15:13] == 3'b000);
      cycle.hit_e3      = (a[7:0] == 8'hE3);
      // The NMI entry is filtered in paging_control
      cycle.trap_deferred  = fetch && (a == TRAP_RST00 || a == TRAP_RST08 ||
                                       a == TRAP_RST38 || a == TRAP_NMI ||
                                       a == TRAP_TAPE_LOAD || a == TRAP_TAPE_SAVE);
      cycle.trap_immediate = fetch && (a[15:8] == TRAP_IMM_PAGE);
      cycle.trap_exit      = fetch && (a[15:3] == TRAP_EXIT_TAG);
      cycle.m1_end         = m1_n;
   end

endmodule

`default_nettype wire

// ==== verilog/paging_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module paging_control import zxmem_bus_pkg::*, zxmem_map_pkg::*; (
   input  logic          clk,
   input  logic          mrst_n,
   input  bus_cycle_t    cycle,
   input  logic          psel,
   input  logic          penable,
   input  logic          pwrite,
   input  logic [7:0]    paddr,
   input  logic [7:0]    pwdata,
   output logic [7:0]    prdata,
   output paging_state_t state
);

   logic       boot_mode;
   logic       divmmc_enabled;
   logic       divmmc_nmi_disabled;
   logic [4:0] mastermapper;
   logic [7:0] bank128;
   logic [7:0] bankplus3;
   logic [7:0] divmmc_ctrl;
   logic       divmmc_pending;     // Mapping to apply when M1 ends
   logic       divmmc_paged;
   logic       apb_wr;
   logic       port_lock;
   logic       deferred_hit;

   ////////////////////////////////////////////////////////////////////////////
   // Boot configuration over APB
   ////////////////////////////////////////////////////////////////////////////
   assign apb_wr = psel && penable && pwrite && boot_mode;   // Locked once boot ends

   always_ff @(posedge clk) begin
      if (!mrst_n)
         {divmmc_nmi_disabled, divmmc_enabled, boot_mode} <= 3'b001;
      else if (apb_wr && paddr == MASTERCONF_ADDR)
         {divmmc_nmi_disabled, divmmc_enabled, boot_mode} <= pwdata[2:0];
   end

   always_ff @(posedge clk) begin
      if (!mrst_n)
         mastermapper <= 5'd0;
      else if (apb_wr && paddr == MASTERMAPPER_ADDR)
         mastermapper <= pwdata[4:0];
   end

   always_comb begin
      case (paddr)
         MASTERCONF_ADDR:   prdata = {6'b0, divmmc_enabled, boot_mode};
         MASTERMAPPER_ADDR: prdata = {3'b0, mastermapper};
         default:           prdata = 8'hFF;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Paging ports
   ////////////////////////////////////////////////////////////////////////////
   assign port_lock = bank128[5];

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         bank128   <= 8'h00;
         bankplus3 <= 8'h00;
      end else if (cycle.io_wr_pulse && !port_lock) begin
         if (cycle.hit_7ffd)      bank128   <= cycle.wdata;
         else if (cycle.hit_1ffd) bankplus3 <= cycle.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n)
         divmmc_ctrl <= 8'h00;
      else if (cycle.io_wr_pulse && cycle.hit_e3)
         divmmc_ctrl <= cycle.wdata;
   end

   // DivMMC automapper
   assign deferred_hit = cycle.trap_deferred &&
                         !(cycle.addr == TRAP_NMI && divmmc_nmi_disabled);

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         divmmc_pending <= 1'b0;
         divmmc_paged   <= 1'b0;
      end else begin
         if (cycle.trap_immediate) begin
            divmmc_paged   <= 1'b1;
            divmmc_pending <= 1'b1;
         end else if (deferred_hit) begin
            divmmc_pending <= 1'b1;
         end else if (cycle.trap_exit) begin
            divmmc_pending <= 1'b0;
         end
         if (cycle.m1_end)
            divmmc_paged <= divmmc_pending;   // Deferred mapping takes effect here
      end
   end

   always_comb begin
      state.boot_mode           = boot_mode;
      state.divmmc_enabled      = divmmc_enabled;
      state.divmmc_nmi_disabled = divmmc_nmi_disabled;
      state.mastermapper        = mastermapper;
      state.bank128             = bank128;
      state.bankplus3           = bankplus3;
      state.divmmc_ctrl         = divmmc_ctrl;
      state.divmmc_paged        = divmmc_paged;
   end

endmodule

`default_nettype wire

// ==== verilog/sram_address_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_address_map import zxmem_bus_pkg::*, zxmem_map_pkg::*; (
   input  bus_cycle_t    cycle,
   input  paging_state_t state,
   output logic [18:0]   sram_addr,
   output logic          sram_we_n,
   output logic [7:0]    sram_wdata,
   input  logic [7:0]    sram_rdata,
   output logic [13:0]   rom_addr,
   output logic          rom_we,
   input  logic [7:0]    rom_rdata,
   output logic [7:0]    dout,
   output logic          oe_n
);

   logic       mem_rd;
   logic       mem_wr;
   logic       boot_area;
   logic       allram;
   logic [1:0] arrangement;
   logic [1:0] rom_sel;
   logic [3:0] div_page;
   logic       mapram;
   logic       conmem;
   logic       div_active;
   logic       wr_block;          // Write to a read-only area

   function automatic logic [18:0] ram_addr(input logic [2:0] page, input logic [13:0] offs);
      return {2'b00, page, offs};
   endfunction

   assign mem_rd      = (cycle.kind == CYC_FETCH) || (cycle.kind == CYC_MEM_RD);
   assign mem_wr      = (cycle.kind == CYC_MEM_WR);
   assign boot_area   = state.boot_mode && (cycle.region == 2'd0);
   assign allram      = state.bankplus3[0];
   assign arrangement = state.bankplus3[2:1];
   assign rom_sel     = {state.bankplus3[2], state.bank128[4]};
   assign div_page    = state.divmmc_ctrl[3:0];
   assign mapram      = state.divmmc_ctrl[6];
   assign conmem      = state.divmmc_ctrl[7];
   assign div_active  = state.divmmc_enabled && (state.divmmc_paged || conmem);

   ////////////////////////////////////////////////////////////////////////////
   // Address per 16K region
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      sram_addr = 19'h00000;
      wr_block  = 1'b0;
      if (mem_rd || mem_wr) begin
         case (cycle.region)
            2'd0: begin
               if (state.boot_mode) begin
                  wr_block = 1'b1;                 // Served by the boot ROM
               end else if (div_active) begin
                  if (!cycle.addr[13]) begin
                     wr_block = 1'b1;
                     if (conmem || !mapram)
                        sram_addr = {DIVMMC_ROM_PREFIX, cycle.addr[12:0]};
                     else
                        sram_addr = {DIVMMC_RAM_PREFIX, DIVMMC_MAPRAM_PAGE, cycle.addr[12:0]};
                  end else begin
                     sram_addr = {DIVMMC_RAM_PREFIX, div_page, cycle.addr[12:0]};
                     wr_block  = !conmem && mapram && (div_page == DIVMMC_MAPRAM_PAGE);
                  end
               end else if (!allram) begin
                  sram_addr = {SYSROM_PREFIX, rom_sel, cycle.addr[13:0]};
                  wr_block  = 1'b1;
               end else begin
                  sram_addr = ram_addr((arrangement == 2'd0) ? PAGE_RAM0 : PAGE_RAM4,
                                       cycle.addr[13:0]);
               end
            end
            2'd1: begin
               if (state.boot_mode || !allram)
                  sram_addr = ram_addr(PAGE_RAM5, cycle.addr[13:0]);
               else
                  case (arrangement)
                     2'd0:    sram_addr = ram_addr(PAGE_RAM1, cycle.addr[13:0]);
                     2'd3:    sram_addr = ram_addr(PAGE_RAM7, cycle.addr[13:0]);
                     default: sram_addr = ram_addr(PAGE_RAM5, cycle.addr[13:0]);
                  endcase
            end
            2'd2: begin
               if (state.boot_mode || !allram || arrangement == 2'd0)
                  sram_addr = ram_addr(PAGE_RAM2, cycle.addr[13:0]);
               else
                  sram_addr = ram_addr(PAGE_RAM6, cycle.addr[13:0]);
            end
            default: begin
               if (state.boot_mode)
                  sram_addr = {state.mastermapper, cycle.addr[13:0]};   // Any 16K of SRAM
               else if (!allram)
                  sram_addr = ram_addr(state.bank128[2:0], cycle.addr[13:0]);
               else if (arrangement == 2'd1)
                  sram_addr = ram_addr(PAGE_RAM7, cycle.addr[13:0]);
               else
                  sram_addr = ram_addr(PAGE_RAM3, cycle.addr[13:0]);
            end
         endcase
      end
   end

   assign sram_we_n  = !(mem_wr && !wr_block);
   assign sram_wdata = cycle.wdata;
   assign rom_addr   = cycle.addr[13:0];
   assign rom_we     = boot_area && mem_wr;

   // CPU read data
   always_comb begin
      if (boot_area && mem_rd) begin
         dout = rom_rdata;
         oe_n = 1'b0;
      end else if (mem_rd) begin
         dout = sram_rdata;
         oe_n = 1'b0;
      end else begin
         dout = 8'hFF;
         oe_n = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
   input  logic        clk,
   input  logic [13:0] addr,
   input  logic        we,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata
);

   logic [7:0] mem [0:16383];

   // Read data lags the address by one clock
   always_ff @(posedge clk) begin
      if (we)
         mem[addr] <= wdata;
      rdata <= mem[addr];    // Old contents on a write
   end

endmodule

`default_nettype wire

// ==== verilog/zx_memory_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_memory_top import zxmem_bus_pkg::*, zxmem_map_pkg::*; (
   input  logic        clk,
   input  logic        mrst_n,
   // CPU bus
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,
   // APB configuration port
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [7:0]  pwdata,
   output logic [7:0]  prdata,
   // External SRAM
   output logic [18:0] sram_addr,
   output logic        sram_we_n,
   output logic [7:0]  sram_wdata,
   input  logic [7:0]  sram_rdata
);

   bus_cycle_t    cycle;
   paging_state_t state;
   logic [13:0]   rom_addr;
   logic          rom_we;
   logic [7:0]    rom_rdata;

   cpu_cycle_decode u_decode (
      .clk(clk), .mrst_n(mrst_n), .mreq_n(mreq_n), .iorq_n(iorq_n),
      .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .a(a), .din(din), .cycle(cycle)
   );

   paging_control u_paging (
      .clk(clk), .mrst_n(mrst_n), .cycle(cycle), .psel(psel), .penable(penable),
      .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .state(state)
   );

   sram_address_map u_map (
      .cycle(cycle), .state(state), .sram_addr(sram_addr), .sram_we_n(sram_we_n),
      .sram_wdata(sram_wdata), .sram_rdata(sram_rdata), .rom_addr(rom_addr),
      .rom_we(rom_we), .rom_rdata(rom_rdata), .dout(dout), .oe_n(oe_n)
   );

   boot_rom u_boot_rom (
      .clk(clk), .addr(rom_addr), .we(rom_we), .wdata(din), .rdata(rom_rdata)
   );

endmodule

`default_nettype wire

// ==== tests/zx_memory_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_memory_assertions import zxmem_bus_pkg::*, zxmem_map_pkg::*; (
   input  logic          clk,
   input  logic          mrst_n,
   input  bus_cycle_t    cycle,
   input  paging_state_t state,
   input  logic          sram_we_n
);

   logic div_active;
   logic rom_area_wr;

   assign div_active  = state.divmmc_enabled && (state.divmmc_paged || state.divmmc_ctrl[7]);
   assign rom_area_wr = (cycle.kind == CYC_MEM_WR) && (cycle.region == 2'd0) &&
                        (state.boot_mode || (!div_active && !state.bankplus3[0]));

   // System ROM pages and the boot ROM area never reach the SRAM write strobe
   rom_write_blocked: assert property (@(posedge clk) disable iff (!mrst_n)
      rom_area_wr |-> sram_we_n)
      else $error("SRAM write strobe active on a ROM page");

   port_lock_holds: assert property (@(posedge clk) disable iff (!mrst_n)
      state.bank128[5] |=> ($stable(state.bank128) && $stable(state.bankplus3)))
      else $error("Paging port changed while locked");

   // Boot configuration is frozen once boot mode ends
   boot_regs_frozen: assert property (@(posedge clk) disable iff (!mrst_n)
      !state.boot_mode |=> (!state.boot_mode && $stable(state.mastermapper) &&
                            $stable(state.divmmc_enabled)))
      else $error("Boot configuration changed after boot");

endmodule

bind zx_memory_top zx_memory_assertions u_checks (
   .clk(clk), .mrst_n(mrst_n), .cycle(cycle), .state(state), .sram_we_n(sram_we_n)
);

`default_nettype wire

// ==== tests/zx_memory_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_memory_tb import zxmem_bus_pkg::*, zxmem_map_pkg::*; ();

   // The tests need under 400 clocks of bus and APB traffic
   localparam int CYCLE_LIMIT = 20000;

   logic        clk, mrst_n;
   logic        mreq_n, iorq_n, rd_n, wr_n, m1_n;
   logic [15:0] a;
   logic [7:0]  din, dout;
   logic        oe_n;
   logic        psel, penable, pwrite;
   logic [7:0]  paddr, pwdata, prdata;
   logic [18:0] sram_addr;
   logic        sram_we_n;
   logic [7:0]  sram_wdata, sram_rdata;

   logic [7:0]  sram [0:524287];
   int          sram_writes = 0;
   int          cycles = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          tests = 0;
   logic [31:0] lfsr = 32'h798f_20bf;

   // Shadow of the paging registers
   logic        sh_boot, sh_div_en, sh_paged;
   logic [4:0]  sh_mm;
   logic [7:0]  sh_7ffd, sh_1ffd, sh_e3;

   // Values seen in the last clock of a CPU cycle
   logic [18:0] got_addr;
   logic        got_we_n, got_oe_n;
   logic [7:0]  got_dout;

   zx_memory_top UUT (
      .clk(clk), .mrst_n(mrst_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n),
      .wr_n(wr_n), .m1_n(m1_n), .a(a), .din(din), .dout(dout), .oe_n(oe_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .sram_addr(sram_addr), .sram_we_n(sram_we_n),
      .sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // SRAM model
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [7:0] fill_value(input logic [18:0] ad);
      return ad[7:0] ^ ad[15:8] ^ {5'b0, ad[18:16]};
   endfunction

   initial begin
      for (int i = 0; i < 524288; i++)
         sram[i] = fill_value(19'(i));
   end

   assign sram_rdata = sram[sram_addr];

   always @(posedge clk) begin
      if (!sram_we_n) begin
         sram[sram_addr] <= sram_wdata;
         sram_writes     <= sram_writes + 1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
   endfunction

   task automatic random_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference memory map
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [18:0] expected_sram_addr(input logic [15:0] ad);
      logic [1:0]  r;
      logic [11:0] row;                  // Four 3-bit pages with region 0 lowest
      logic        conm;
      logic        div_on;
      r      = ad[15:14];
      conm   = sh_e3[7];
      div_on = sh_div_en && (sh_paged || conm);
      if (sh_boot && r == 2'd0) return 19'h0;             // Boot ROM
      if (sh_boot && r == 2'd3) return {sh_mm, ad[13:0]};
      if (r == 2'd0 && div_on) begin
         if (ad[13]) return {2'b10, sh_e3[3:0], ad[12:0]};
         if (conm || !sh_e3[6]) return {6'b011000, ad[12:0]};
         return {2'b10, 4'd3, ad[12:0]};                    // mapram
      end
      if (!sh_boot && sh_1ffd[0]) begin
         case (sh_1ffd[2:1])
            2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
            2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
            2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
            default: row = {3'd3, 3'd6, 3'd7, 3'd4};
         endcase
         return {2'b00, row[r*3 +: 3], ad[13:0]};
      end
      case (r)
         2'd0:    return {3'b010, sh_1ffd[2], sh_7ffd[4], ad[13:0]};
         2'd1:    return {5'd5, ad[13:0]};
         2'd2:    return {5'd2, ad[13:0]};
         default: return {2'b00, sh_7ffd[2:0], ad[13:0]};
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic cpu_cycle(input cycle_kind_e k, input logic [15:0] ad, input logic [7:0] d);
      @(negedge clk);
      a   = ad;
      din = d;
      case (k)
         CYC_FETCH:  {mreq_n, rd_n, m1_n} = 3'b000;
         CYC_MEM_RD: {mreq_n, rd_n} = 2'b00;
         CYC_MEM_WR: {mreq_n, wr_n} = 2'b00;
         CYC_IO_RD:  {iorq_n, rd_n} = 2'b00;
         CYC_IO_WR:  {iorq_n, wr_n} = 2'b00;
         default:    ;
      endcase
      repeat (2) @(negedge clk);
      got_addr = sram_addr;
      got_we_n = sram_we_n;
      got_dout = dout;
      got_oe_n = oe_n;
      @(negedge clk);
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;   // Idle clock ends m1
   endtask

   task automatic apb_xfer(input logic wr, input logic [7:0] ad, input logic [7:0] d,
                           output logic [7:0] rd);
      @(negedge clk);
      {psel, pwrite, paddr, pwdata} = {1'b1, wr, ad, d};
      @(negedge clk);
      penable = 1'b1;
      #2 rd = prdata;
      @(negedge clk);
      {psel, penable} = 2'b00;
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic read_check(input cycle_kind_e k, input logic [15:0] ad);
      logic [18:0] exp;
      exp = expected_sram_addr(ad);
      cpu_cycle(k, ad, 8'h00);
      check("sram_addr", got_addr, exp);
      check("oe_n", got_oe_n, 0);
      check("dout", got_dout, sram[exp]);
   endtask

   task automatic end_test(input string name);
      if (test_errors == 0) $display("test %s: ok", name);
      else                  $display("test %s: %0d errors", name, test_errors);
      tests++;
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] r1, r2;
      logic [7:0]  rd;
      int          w0;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
      {a, din, psel, penable, pwrite, paddr, pwdata} = '0;
      mrst_n = 1'b0;
      {sh_boot, sh_div_en, sh_paged, sh_mm} = {3'b100, 5'd0};
      {sh_7ffd, sh_1ffd, sh_e3} = '0;
      repeat (3) @(posedge clk);
      @(negedge clk) mrst_n = 1'b1;

      // Boot ROM and master mapper
      random_bits(14, r1);
      random_bits(8, r2);
      w0 = sram_writes;
      cpu_cycle(CYC_MEM_WR, {2'b00, r1[13:0]}, r2[7:0]);
      check("sram_we_n", got_we_n, 1);
      cpu_cycle(CYC_MEM_RD, {2'b00, r1[13:0]}, 8'h00);
      check("dout", got_dout, r2[7:0]);
      check("oe_n", got_oe_n, 0);
      if (sram_writes != w0) begin
         $display("Boot ROM write reached the SRAM");
         errors++;
         test_errors++;
      end
      apb_xfer(1'b1, MASTERMAPPER_ADDR, 8'h13, rd);
      sh_mm = 5'h13;
      random_bits(14, r1);
      read_check(CYC_MEM_RD, {2'b11, r1[13:0]});
      end_test("boot_mode");

      // APB registers and the boot lock
      apb_xfer(1'b0, MASTERCONF_ADDR, 8'h00, rd);
      check("prdata", rd, 8'h01);
      apb_xfer(1'b0, MASTERMAPPER_ADDR, 8'h00, rd);
      check("prdata", rd, 8'h13);
      apb_xfer(1'b0, 8'h7E, 8'h00, rd);
      check("prdata", rd, 8'hFF);
      apb_xfer(1'b1, MASTERCONF_ADDR, 8'h02, rd);   // DivMMC on and boot off
      {sh_boot, sh_div_en} = 2'b01;
      apb_xfer(1'b1, MASTERMAPPER_ADDR, 8'h05, rd);
      apb_xfer(1'b1, MASTERCONF_ADDR, 8'h01, rd);
      apb_xfer(1'b0, MASTERCONF_ADDR, 8'h00, rd);
      check("prdata", rd, 8'h02);
      apb_xfer(1'b0, MASTERMAPPER_ADDR, 8'h00, rd);
      check("prdata", rd, 8'h13);
      end_test("apb_config");

      // 128K banking and ROM select
      for (int b = 0; b < 8; b++) begin
         random_bits(15, r1);
         sh_7ffd = {3'b000, r1[14], 1'b0, 3'(b)};
         cpu_cycle(CYC_IO_WR, 16'h7FFD, sh_7ffd);
         read_check(CYC_MEM_RD, {2'b11, r1[13:0]});
         read_check(CYC_MEM_RD, {2'b00, r1[13:0]});
      end
      sh_1ffd = 8'h04;
      cpu_cycle(CYC_IO_WR, 16'h1FFD, sh_1ffd);
      read_check(CYC_MEM_RD, {2'b00, r1[13:0]});
      end_test("bank_7ffd");

      // +3 all-RAM arrangements
      for (int m = 0; m < 4; m++) begin
         sh_1ffd = {5'b0, 2'(m), 1'b1};
         cpu_cycle(CYC_IO_WR, 16'h1FFD, sh_1ffd);
         for (int r = 0; r < 4; r++) begin
            random_bits(14, r1);
            read_check(CYC_MEM_RD, {2'(r), r1[13:0]});
         end
      end
      sh_1ffd = 8'h00;
      cpu_cycle(CYC_IO_WR, 16'h1FFD, sh_1ffd);
      end_test("allram_1ffd");

      // DivMMC conmem and automapper
      random_bits(4, r1);
      sh_e3 = {4'b1000, r1[3:0]};
      cpu_cycle(CYC_IO_WR, 16'h00E3, sh_e3);
      read_check(CYC_MEM_RD, 16'h0123);
      read_check(CYC_MEM_RD, 16'h2345);
      cpu_cycle(CYC_MEM_WR, 16'h0100, 8'h5A);
      check("sram_we_n", got_we_n, 1);
      cpu_cycle(CYC_MEM_WR, 16'h2100, 8'hA5);
      check("sram_we_n", got_we_n, 0);
      read_check(CYC_MEM_RD, 16'h2100);
      check("dout", got_dout, 8'hA5);
      sh_e3 = {4'b0000, r1[3:0]};
      cpu_cycle(CYC_IO_WR, 16'h00E3, sh_e3);
      read_check(CYC_FETCH, 16'h0038);              // Still unmapped during m1
      sh_paged = 1'b1;
      read_check(CYC_MEM_RD, 16'h0100);
      read_check(CYC_FETCH, 16'h1FF8);
      sh_paged = 1'b0;
      read_check(CYC_MEM_RD, 16'h0100);
      sh_paged = 1'b1;
      read_check(CYC_FETCH, 16'h3D00);              // Maps within the fetch
      read_check(CYC_FETCH, 16'h1FFC);
      sh_paged = 1'b0;
      read_check(CYC_MEM_RD, 16'h0100);
      end_test("divmmc");

      // SRAM data path and idle bus
      for (int i = 0; i < 4; i++) begin
         random_bits(14, r1);
         random_bits(8, r2);
         cpu_cycle(CYC_MEM_WR, {2'b10, r1[13:0]}, r2[7:0]);
         check("sram_we_n", got_we_n, 0);
         read_check(CYC_MEM_RD, {2'b10, r1[13:0]});
         check("dout", got_dout, r2[7:0]);
      end
      cpu_cycle(CYC_IDLE, 16'h8000, 8'h00);
      check("dout", got_dout, 8'hFF);
      check("oe_n", got_oe_n, 1);
      end_test("data_path");

      // Port lock in $7FFD bit 5
      sh_7ffd = 8'h36;
      cpu_cycle(CYC_IO_WR, 16'h7FFD, sh_7ffd);
      cpu_cycle(CYC_IO_WR, 16'h7FFD, 8'h01);
      cpu_cycle(CYC_IO_WR, 16'h1FFD, 8'h01);
      read_check(CYC_MEM_RD, 16'hC010);
      read_check(CYC_MEM_RD, 16'h0010);
      end_test("port_lock");

      $display("%0d tests, %0d errors, %0d cycles", tests, errors, cycles);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== zx_memory.f ====
verilog/zxmem_bus_pkg.sv
verilog/zxmem_map_pkg.sv
verilog/cpu_cycle_decode.sv
verilog/paging_control.sv
verilog/sram_address_map.sv
verilog/boot_rom.sv
verilog/zx_memory_top.sv
tests/zx_memory_assertions.sv
tests/zx_memory_tb.sv

// ==== Makefile ====
SIM = obj_dir/zx_memory_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): zx_memory.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module zx_memory_tb \
		-f zx_memory.f -o zx_memory_sim

run: $(SIM)
	-./$(SIM) > run.log 2>&1
	@cat run.log
	@if grep -q "\*\*\* TEST FAILED \*\*\*" run.log; then exit 1; fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" run.log; then exit 1; fi

clean:
	rm -rf obj_dir run.log
